// ==== Makefile ====
TOP := tb_vid_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb_vid_top.sv ====
`default_nettype none

`include "vid_macros.svh"

module tb_vid_top import vid_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME       = `VID_H_TOTAL * `VID_V_TOTAL;
  localparam int APB_TIMEOUT = 64;

  typedef enum logic {OP_WR, OP_RD} op_e;

  typedef struct {
    op_e         op;
    logic [3:0]  offset;
    logic [31:0] data;
    logic [31:0] expected;
    logic        exp_err;
  } entry_t;

  logic        vga_clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  vid_video_t  video;

  entry_t      table_q [$];
  logic [15:0] fb_model [`VID_FB_WORDS];
  logic [15:0] lfsr;

  vid_top vid_top_i (
    .vga_clk (vga_clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .video   (video)
  );

  always #5 vga_clk = ~vga_clk;

  //////////////////////////////
  // random source and reporting
  //////////////////////////////

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_video(input string name, input vid_video_t got,
                             input vid_video_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // apb and table
  //////////////////////////////

  task automatic apb_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    @(negedge vga_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge vga_clk);
    penable = 1'b1;
    #1;
    waits = 0;
    while (!pready) begin
      if (waits == APB_TIMEOUT) begin
        stop_run("timeout waiting for pready on an apb transfer");
      end
      @(negedge vga_clk);
      #1;
      waits++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge vga_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic add_entry(input op_e op, input logic [3:0] offset, input logic [31:0] data,
                           input logic [31:0] expected, input logic exp_err);
    entry_t e;
    e.op       = op;
    e.offset   = offset;
    e.data     = data;
    e.expected = expected;
    e.exp_err  = exp_err;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] v;
    // display starts disabled
    add_entry(OP_RD, `VID_REG_CTRL, 32'h0, 32'h0, 1'b0);
    add_entry(OP_WR, `VID_REG_CTRL, 32'h1, 32'h0, 1'b0);
    add_entry(OP_RD, `VID_REG_CTRL, 32'h0, 32'h1, 1'b0);
    // whole frame from address 0, upper half of the bus word ignored
    add_entry(OP_WR, `VID_REG_FB_ADDR, 32'h0, 32'h0, 1'b0);
    for (int i = 0; i < `VID_FB_WORDS; i++) begin
      take_bits(16, v);
      fb_model[i] = v[15:0];
      add_entry(OP_WR, `VID_REG_FB_DATA, {~v[15:0], v[15:0]}, 32'h0, 1'b0);
    end
    add_entry(OP_RD, `VID_REG_FB_ADDR, 32'h0, 32'(`VID_FB_WORDS % `VID_FB_WORDS), 1'b0);
    // short run across the top of memory
    add_entry(OP_WR, `VID_REG_FB_ADDR, 32'd120, 32'h0, 1'b0);
    for (int i = 0; i < 12; i++) begin
      take_bits(16, v);
      fb_model[(120 + i) % `VID_FB_WORDS] = v[15:0];
      add_entry(OP_WR, `VID_REG_FB_DATA, v, 32'h0, 1'b0);
    end
    add_entry(OP_RD, `VID_REG_FB_ADDR, 32'h0, 32'((120 + 12) % `VID_FB_WORDS), 1'b0);
    // random readback, twice so the address must hold
    for (int i = 0; i < 8; i++) begin
      take_bits(7, v);
      add_entry(OP_WR, `VID_REG_FB_ADDR, v, 32'h0, 1'b0);
      add_entry(OP_RD, `VID_REG_FB_DATA, 32'h0, {16'h0, fb_model[v[6:0]]}, 1'b0);
      add_entry(OP_RD, `VID_REG_FB_DATA, 32'h0, {16'h0, fb_model[v[6:0]]}, 1'b0);
      add_entry(OP_RD, `VID_REG_FB_ADDR, 32'h0, v, 1'b0);
    end
    // unmapped offsets, display_en bit clear in the write data
    add_entry(OP_WR, 4'hC, 32'hFFFF_FFFE, 32'h0, 1'b1);
    add_entry(OP_RD, 4'hC, 32'h0, 32'h0, 1'b1);
    add_entry(OP_RD, 4'h2, 32'h0, 32'h0, 1'b1);
    add_entry(OP_RD, `VID_REG_FB_ADDR, 32'h0, v, 1'b0);
    add_entry(OP_RD, `VID_REG_CTRL, 32'h0, 32'h1, 1'b0);
  endtask

  task automatic apply_table();
    logic [31:0] rdata;
    logic        err;
    logic [31:0] idle;
    foreach (table_q[i]) begin
      // random gap shifts reads against the fetch window
      take_bits(3, idle);
      repeat (idle) @(negedge vga_clk);
      apb_access(table_q[i].op == OP_WR, table_q[i].offset, table_q[i].data, rdata, err);
      check_err($sformatf("pslverr entry %0d", i), err, table_q[i].exp_err);
      if (table_q[i].op == OP_RD) begin
        check_word($sformatf("prdata entry %0d", i), rdata, table_q[i].expected);
      end
    end
  endtask

  //////////////////////////////
  // raster checks
  //////////////////////////////

  function automatic vid_video_t expected_video(input int x, input int y, input logic en);
    int          red_bits [8];
    int          green_bits [8];
    int          blue_bits [8];
    vid_video_t  v;
    logic [15:0] w;
    red_bits   = '{4, 3, 2, 2, 1, 1, 0, 0};
    green_bits = '{10, 9, 8, 7, 6, 6, 5, 5};
    blue_bits  = '{15, 14, 13, 13, 12, 12, 11, 11};
    v = '0;
    v.hsync = (x >= `VID_H_SYNC_START) && (x < `VID_H_SYNC_END);
    v.vsync = (y >= `VID_V_SYNC_START) && (y < `VID_V_SYNC_END);
    v.blank = !((x < `VID_H_ACTIVE) && (y < `VID_V_ACTIVE));
    if (en && !v.blank) begin
      w = fb_model[y * `VID_H_ACTIVE + x];
      for (int i = 0; i < 8; i++) begin
        v.r[7 - i] = w[red_bits[i]];
        v.g[7 - i] = w[green_bits[i]];
        v.b[7 - i] = w[blue_bits[i]];
      end
    end
    return v;
  endfunction

  // cycles counted from call until the chosen sync reaches the level
  task automatic wait_sync_edge(input logic use_vsync, input logic rise, output int cycles);
    logic prev;
    logic cur;
    cycles = 0;
    cur = use_vsync ? video.vsync : video.hsync;
    do begin
      if (cycles == 2 * FRAME) begin
        stop_run("timeout waiting for a sync edge on the video output");
      end
      prev = cur;
      @(negedge vga_clk);
      cur = use_vsync ? video.vsync : video.hsync;
      cycles++;
    end while (!(prev == !rise && cur == rise));
  endtask

  task automatic check_frame(input logic en);
    int x;
    int y;
    int n;
    wait_sync_edge(1'b1, 1'b0, n);
    // first line after the vsync pulse
    x = 0;
    y = `VID_V_SYNC_END;
    for (int k = 0; k < FRAME; k++) begin
      check_video($sformatf("video x=%0d y=%0d", x, y), video, expected_video(x, y, en));
      x++;
      if (x == `VID_H_TOTAL) begin
        x = 0;
        y = (y + 1) % `VID_V_TOTAL;
      end
      @(negedge vga_clk);
    end
  endtask

  task automatic measure_sync();
    int n;
    int width;
    wait_sync_edge(1'b0, 1'b1, n);
    wait_sync_edge(1'b0, 1'b0, width);
    check_word("hsync width", width, `VID_H_SYNC_END - `VID_H_SYNC_START);
    wait_sync_edge(1'b0, 1'b1, n);
    check_word("hsync period", width + n, `VID_H_TOTAL);
    wait_sync_edge(1'b1, 1'b1, n);
    wait_sync_edge(1'b1, 1'b0, width);
    check_word("vsync width", width,
               (`VID_V_SYNC_END - `VID_V_SYNC_START) * `VID_H_TOTAL);
    wait_sync_edge(1'b1, 1'b1, n);
    check_word("vsync period", width + n, FRAME);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    vid_video_t  idle_video;
    logic [31:0] rdata;
    logic        err;
    vga_clk = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    lfsr    = 16'd767;
    build_table();
    repeat (3) @(posedge vga_clk);
    @(negedge vga_clk);
    rst_n = 1'b1;
    idle_video = '0;
    idle_video.blank = 1'b1;
    check_video("video after reset", video, idle_video);
    check_err("pready after reset", pready, 1'b0);
    check_err("pslverr after reset", pslverr, 1'b0);
    apply_table();
    check_frame(1'b1);
    apb_access(1'b1, `VID_REG_CTRL, 32'h0, rdata, err);
    check_err("pslverr ctrl clear", err, 1'b0);
    check_frame(1'b0);
    measure_sync();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vid_assertions.sv ====
`default_nettype none

module vid_assertions import vid_pkg::*; (
  input  wire logic vga_clk,
  input  wire logic rst_n,
  input  wire logic penable,
  input  wire logic pready,
  input  vid_video_t video
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // apb
  //////////////////////////////

  pready_in_access: assert property (
    @(posedge vga_clk) disable iff (!rst_n) pready |-> penable
  ) else $error("pready high outside the access phase");

  //////////////////////////////
  // video output
  //////////////////////////////

  // sync pulses sit in the blanking interval
  sync_in_blank: assert property (
    @(posedge vga_clk) disable iff (!rst_n) (video.hsync || video.vsync) |-> video.blank
  ) else $error("sync pulse outside blanking");

  black_in_blank: assert property (
    @(posedge vga_clk) disable iff (!rst_n) video.blank |-> ({video.r, video.g, video.b} == '0)
  ) else $error("colour not black during blanking");

endmodule

bind vid_top vid_assertions vid_assertions_i (
  .vga_clk (vga_clk),
  .rst_n   (rst_n),
  .penable (penable),
  .pready  (pready),
  .video   (video)
);

`default_nettype wire

// ==== vid_framebuf.sv ====
`default_nettype none

`include "vid_macros.svh"

module vid_framebuf import vid_pkg::*; (
  input  wire logic vga_clk,
  input  wire logic rst_n,
  input  vid_fb_wr_t wr,
  input  vid_fb_rd_t fetch_rd,
  input  vid_fb_rd_t host_rd,
  output vid_pixel_u rd_data,
  output logic       fetch_rd_valid,
  output logic       host_rd_valid
);

  vid_pixel_u              mem [`VID_FB_WORDS];
  logic [`VID_FB_AW-1:0]   rd_addr;

  // fetcher wins, host only on idle cycles
  assign rd_addr = fetch_rd.valid ? fetch_rd.addr : host_rd.addr;

  always_ff @(posedge vga_clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.pixel;
    end
    rd_data <= mem[rd_addr];
  end

  // tag the returned word with its requester
  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_rd_valid <= 1'b0;
      host_rd_valid  <= 1'b0;
    end else begin
      fetch_rd_valid <= fetch_rd.valid;
      host_rd_valid  <= host_rd.valid & ~fetch_rd.valid;
    end
  end

endmodule

`default_nettype wire

// ==== vid_line_fetch.sv ====
`default_nettype none

`include "vid_macros.svh"

module vid_line_fetch import vid_pkg::*; (
  input  wire logic   vga_clk,
  input  wire logic   rst_n,
  input  vid_timing_t timing_in,
  output vid_fb_rd_t  fetch_rd,
  input  vid_pixel_u  rd_data,
  input  wire logic   fetch_rd_valid,
  output vid_timing_t timing_out,
  output vid_pixel_u  pixel
);

  localparam int XW = $clog2(`VID_H_ACTIVE);
  localparam int AW = `VID_FB_AW;

  // two rows, half picked by row parity
  vid_pixel_u    line_buf [2 * `VID_H_ACTIVE];
  logic [11:0]   y_next;
  logic          start;
  logic          fetching;
  logic [XW-1:0] req_cnt;
  logic [AW-1:0] rd_addr;
  logic [XW-1:0] wr_col;
  logic          fill_half;

  // row to fetch during this line
  assign y_next = (timing_in.pos.y == 12'(`VID_V_TOTAL - 1)) ? '0 : timing_in.pos.y + 12'd1;
  assign start  = (timing_in.pos.x == '0) && !fetching && (y_next < 12'(`VID_V_ACTIVE));

  assign fetch_rd.valid = fetching;
  assign fetch_rd.addr  = rd_addr;

  //////////////////////////////
  // fetch control
  //////////////////////////////

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      fetching  <= 1'b0;
      req_cnt   <= '0;
      rd_addr   <= '0;
      wr_col    <= '0;
      fill_half <= 1'b0;
    end else begin
      if (start) begin
        fetching  <= 1'b1;
        req_cnt   <= '0;
        rd_addr   <= AW'(y_next * `VID_H_ACTIVE);
        wr_col    <= '0;
        fill_half <= y_next[0];
      end else begin
        // fetch reads are never refused
        if (fetching) begin
          rd_addr <= rd_addr + 1'b1;
          req_cnt <= req_cnt + 1'b1;
          if (req_cnt == XW'(`VID_H_ACTIVE - 1)) begin
            fetching <= 1'b0;
          end
        end
        if (fetch_rd_valid) begin
          wr_col <= wr_col + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // line buffer
  //////////////////////////////

  // halves swap with y parity, so at each line boundary
  always_ff @(posedge vga_clk) begin
    if (fetch_rd_valid) begin
      line_buf[{fill_half, wr_col}] <= rd_data;
    end
    pixel <= line_buf[{timing_in.pos.y[0], timing_in.pos.x[XW-1:0]}];
  end

  // timing delayed to match the buffer read
  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      timing_out <= '0;
    end else begin
      timing_out <= timing_in;
    end
  end

endmodule

`default_nettype wire

// ==== vid_macros.svh ====
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

//////////////////////////////
// raster geometry
//////////////////////////////

// horizontal, in pixels
`define VID_H_ACTIVE      16
`define VID_H_SYNC_START  20
`define VID_H_SYNC_END    22
`define VID_H_TOTAL       24

// vertical, in lines
`define VID_V_ACTIVE      8
`define VID_V_SYNC_START  9
`define VID_V_SYNC_END    10
`define VID_V_TOTAL       12

//////////////////////////////
// framebuffer
//////////////////////////////

// one word per visible pixel, row-major
`define VID_FB_WORDS      128
`define VID_FB_AW         7

// apb register offsets
`define VID_REG_CTRL      4'h0
`define VID_REG_FB_ADDR   4'h4
`define VID_REG_FB_DATA   4'h8

`endif

// ==== vid_pixel_out.sv ====
`default_nettype none

module vid_pixel_out import vid_pkg::*; (
  input  wire logic   vga_clk,
  input  wire logic   rst_n,
  input  vid_timing_t timing_in,
  input  vid_pixel_u  pixel,
  input  vid_ctrl_t   ctrl,
  output vid_video_t  video
);

  logic show;

  // 5 bit field to 8 bits, low bits doubled
  function automatic logic [7:0] expand5(input logic [4:0] c);
    return {c[4], c[3], c[2], c[2], c[1], c[1], c[0], c[0]};
  endfunction

  function automatic logic [7:0] expand6(input logic [5:0] c);
    return {c[5], c[4], c[3], c[2], c[1], c[1], c[0], c[0]};
  endfunction

  assign show = timing_in.active & ctrl.display_en;

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      video.hsync <= 1'b0;
      video.vsync <= 1'b0;
      video.blank <= 1'b1;
      video.r     <= '0;
      video.g     <= '0;
      video.b     <= '0;
    end else begin
      video.hsync <= timing_in.hsync;
      video.vsync <= timing_in.vsync;
      video.blank <= ~timing_in.active;
      // black outside the active area or when disabled
      video.r     <= show ? expand5(pixel.rgb.red)   : 8'h00;
      video.g     <= show ? expand6(pixel.rgb.green) : 8'h00;
      video.b     <= show ? expand5(pixel.rgb.blue)  : 8'h00;
    end
  end

endmodule

`default_nettype wire

// ==== vid_pkg.sv ====
`default_nettype none

`include "vid_macros.svh"

package vid_pkg;

  // raster position
  typedef struct packed {
    logic [11:0] x;
    logic [11:0] y;
  } vid_pos_t;

  // position plus sync and active flags
  typedef struct packed {
    vid_pos_t pos;
    logic     hsync;
    logic     vsync;
    logic     active;
  } vid_timing_t;

  // 5-6-5 colour, blue in the top bits
  typedef struct packed {
    logic [4:0] blue;
    logic [5:0] green;
    logic [4:0] red;
  } vid_rgb565_t;

  // stored word, seen as a bus word or as colour
  typedef union packed {
    logic [15:0] raw;
    vid_rgb565_t rgb;
  } vid_pixel_u;

  typedef struct packed {
    logic                  valid;
    logic [`VID_FB_AW-1:0] addr;
    vid_pixel_u            pixel;
  } vid_fb_wr_t;

  typedef struct packed {
    logic                  valid;
    logic [`VID_FB_AW-1:0] addr;
  } vid_fb_rd_t;

  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       blank;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } vid_video_t;

  typedef struct packed {
    logic [30:0] reserved;
    logic        display_en;
  } vid_ctrl_t;

endpackage

`default_nettype wire

// ==== vid_regs.sv ====
`default_nettype none

`include "vid_macros.svh"

module vid_regs import vid_pkg::*; (
  input  wire logic        vga_clk,
  input  wire logic        rst_n,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [3:0]  paddr,
  input  wire logic [31:0] pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             pslverr,
  output vid_fb_wr_t       fb_wr,
  output vid_fb_rd_t       host_rd,
  input  vid_pixel_u       host_rd_data,
  input  wire logic        host_rd_valid,
  output vid_ctrl_t        ctrl
);

  localparam int AW = `VID_FB_AW;

  logic          setup;
  logic          access;
  logic          sel_ctrl;
  logic          sel_addr;
  logic          sel_data;
  logic          unmapped;
  logic          data_rd;
  logic          display_en;
  logic [AW-1:0] fb_addr;
  logic          rd_req;
  logic          rd_done;
  vid_pixel_u    rd_word;

  //////////////////////////////
  // apb decode
  //////////////////////////////

  assign setup    = psel & ~penable;
  assign access   = psel & penable;
  assign sel_ctrl = (paddr == `VID_REG_CTRL);
  assign sel_addr = (paddr == `VID_REG_FB_ADDR);
  assign sel_data = (paddr == `VID_REG_FB_DATA);
  assign unmapped = ~(sel_ctrl | sel_addr | sel_data);
  assign data_rd  = sel_data & ~pwrite;

  // only a framebuffer read waits
  assign pready  = access & (~data_rd | rd_done);
  assign pslverr = access & unmapped;

  always_comb begin
    prdata = '0;
    if (sel_ctrl) begin
      prdata = ctrl;
    end else if (sel_addr) begin
      prdata = 32'(fb_addr);
    end else if (sel_data) begin
      prdata = 32'(rd_word.raw);
    end
  end

  assign ctrl.display_en = display_en;
  assign ctrl.reserved   = '0;

  // data writes go straight to memory at the current address
  assign fb_wr.valid     = access & pwrite & sel_data;
  assign fb_wr.addr      = fb_addr;
  assign fb_wr.pixel.raw = pwdata[15:0];

  // drop the request once the data is back
  assign host_rd.valid = rd_req & ~host_rd_valid;
  assign host_rd.addr  = fb_addr;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      display_en <= 1'b0;
      fb_addr    <= '0;
      rd_req     <= 1'b0;
      rd_done    <= 1'b0;
    end else begin
      if (access & pwrite & sel_ctrl) begin
        display_en <= pwdata[0];
      end

      if (access & pwrite & sel_addr) begin
        fb_addr <= pwdata[AW-1:0];
      end else if (fb_wr.valid) begin
        // auto-increment with wrap
        fb_addr <= (fb_addr == AW'(`VID_FB_WORDS - 1)) ? '0 : fb_addr + 1'b1;
      end

      // request goes out from the setup phase
      if (setup & data_rd) begin
        rd_req <= 1'b1;
      end else if (rd_req & host_rd_valid) begin
        rd_req <= 1'b0;
      end

      if (rd_req & host_rd_valid) begin
        rd_done <= 1'b1;
      end else if (access & pready) begin
        rd_done <= 1'b0;
      end
    end
  end

  // read data held for the access phase
  always_ff @(posedge vga_clk) begin
    if (rd_req & host_rd_valid) begin
      rd_word <= host_rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== vid_timing.sv ====
`default_nettype none

`include "vid_macros.svh"

module vid_timing import vid_pkg::*; (
  input  wire logic  vga_clk,
  input  wire logic  rst_n,
  output vid_timing_t timing
);

  logic [11:0] x_cnt;
  logic [11:0] y_cnt;

  //////////////////////////////
  // raster counters
  //////////////////////////////

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (x_cnt == 12'(`VID_H_TOTAL - 1)) begin
      x_cnt <= '0;
      if (y_cnt == 12'(`VID_V_TOTAL - 1)) begin
        y_cnt <= '0;
      end else begin
        y_cnt <= y_cnt + 12'd1;
      end
    end else begin
      x_cnt <= x_cnt + 12'd1;
    end
  end

  //////////////////////////////
  // registered position and flags
  //////////////////////////////

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      timing <= '0;
    end else begin
      timing.pos.x  <= x_cnt;
      timing.pos.y  <= y_cnt;
      timing.hsync  <= (x_cnt >= 12'(`VID_H_SYNC_START)) &&
                       (x_cnt <  12'(`VID_H_SYNC_END));
      timing.vsync  <= (y_cnt >= 12'(`VID_V_SYNC_START)) &&
                       (y_cnt <  12'(`VID_V_SYNC_END));
      timing.active <= (x_cnt < 12'(`VID_H_ACTIVE)) &&
                       (y_cnt < 12'(`VID_V_ACTIVE));
    end
  end

endmodule

`default_nettype wire

// ==== vid_top.sv ====
`default_nettype none

module vid_top import vid_pkg::*; (
  input  wire logic        vga_clk,
  input  wire logic        rst_n,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [3:0]  paddr,
  input  wire logic [31:0] pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             pslverr,
  output vid_video_t       video
);

  vid_fb_wr_t  fb_wr;
  vid_fb_rd_t  host_rd;
  vid_fb_rd_t  fetch_rd;
  vid_pixel_u  rd_data;
  logic        host_rd_valid;
  logic        fetch_rd_valid;
  vid_ctrl_t   ctrl;
  vid_timing_t timing;
  vid_timing_t timing_d;
  vid_pixel_u  pixel;

  //////////////////////////////
  // host side
  //////////////////////////////

  vid_regs vid_regs_i (
    .vga_clk       (vga_clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .fb_wr         (fb_wr),
    .host_rd       (host_rd),
    .host_rd_data  (rd_data),
    .host_rd_valid (host_rd_valid),
    .ctrl          (ctrl)
  );

  vid_framebuf vid_framebuf_i (
    .vga_clk        (vga_clk),
    .rst_n          (rst_n),
    .wr             (fb_wr),
    .fetch_rd       (fetch_rd),
    .host_rd        (host_rd),
    .rd_data        (rd_data),
    .fetch_rd_valid (fetch_rd_valid),
    .host_rd_valid  (host_rd_valid)
  );

  //////////////////////////////
  // video pipeline
  //////////////////////////////

  vid_timing vid_timing_i (
    .vga_clk (vga_clk),
    .rst_n   (rst_n),
    .timing  (timing)
  );

  vid_line_fetch vid_line_fetch_i (
    .vga_clk        (vga_clk),
    .rst_n          (rst_n),
    .timing_in      (timing),
    .fetch_rd       (fetch_rd),
    .rd_data        (rd_data),
    .fetch_rd_valid (fetch_rd_valid),
    .timing_out     (timing_d),
    .pixel          (pixel)
  );

  vid_pixel_out vid_pixel_out_i (
    .vga_clk   (vga_clk),
    .rst_n     (rst_n),
    .timing_in (timing_d),
    .pixel     (pixel),
    .ctrl      (ctrl),
    .video     (video)
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
vid_pkg.sv
vid_regs.sv
vid_framebuf.sv
vid_timing.sv
vid_line_fetch.sv
vid_pixel_out.sv
vid_top.sv
vid_assertions.sv
tb_vid_top.sv
